// File: flist.f
+incdir+verification
common/addr_pkg.sv
common/cycle_pkg.sv
hdl/address_register.sv
bus_sequencer/phase_timer.sv
bus_sequencer/bus_cycle_fsm.sv
hdl/address_bus_driver.sv
hdl/device_decoder.sv
hdl/autoindex_detect.sv
hdl/address_unit.sv
verification/tb_address_unit.sv

// File: run_sim.sh
#!/bin/sh
# build and run the address unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --timescale 1ns/1ns \
   --top-module tb_address_unit \
   -f flist.f \
   -o sim_address_unit

# the log decides the result, so a stopped run still gets searched
./obj_dir/sim_address_unit > sim.log 2>&1 || true
cat sim.log

if grep -qx '>>> PASS' sim.log; then
   exit 0
fi
exit 1

// File: verification/address_unit_model.svh
`ifndef ADDRESS_UNIT_MODEL_SVH
`define ADDRESS_UNIT_MODEL_SVH

////////////////////////////////////////////////////////////
// reference decode
////////////////////////////////////////////////////////////

// device selects packed as {nsysdev, niodev1, niodev2, niodev3}
// a device is picked only in an io cycle, with ab[15:11] all zero
// and a page of 0 to 3 in ab[10:8]
function automatic logic [3:0] expected_selects(input addr_t a, input logic io_cycle);
   logic [3:0] sel;
   sel = 4'b1111;
   if (io_cycle && (a[15:11] == 5'd0)) begin
      case (a[10:8])
         3'd0:    sel = 4'b0111;
         3'd1:    sel = 4'b1011;
         3'd2:    sel = 4'b1101;
         3'd3:    sel = 4'b1110;
         // pages 4..7 select nothing
         default: sel = 4'b1111;
      endcase
   end
   return sel;
endfunction

// autoindex window, 0x0080 up to and including 0x00ff
function automatic logic in_autoindex_window(input addr_t a);
   return (a >= 16'h0080) && (a <= 16'h00ff);
endfunction

////////////////////////////////////////////////////////////
// compare
////////////////////////////////////////////////////////////

task automatic check_value(input string name,
                           input logic [15:0] expected,
                           input logic [15:0] actual);
   check_count++;
   if (actual !== expected) begin
      error_count++;
      $display("** Error at %0t ns: %s expected 0x%04h, actual 0x%04h",
               $time, name, expected, actual);
   end
endtask

`endif

// File: verification/tb_address_unit.sv
`timescale 1ns/1ns
`default_nettype none

// testbench for the address unit
// a cycle level reference model follows the inputs on every rising
// edge, the checker compares all outputs at the falling edge
module tb_address_unit import addr_pkg::*; ();

   localparam int CYCLE_LEN    = 4;
   localparam int NUM_IO       = 200;
   // bus cycles requested by all tests together
   localparam int TOTAL_CYCLES = 1 + NUM_IO + NUM_IO / 4 + 2 + 6;
   localparam int TIMEOUT_CLKS = 40 * TOTAL_CYCLES * CYCLE_LEN;

   logic  clk;
   logic  rst_n;
   addr_t ibus;
   logic  nwar;
   logic  mem_req;
   logic  io_req;
   logic  fetch;
   logic  end_instr;
   addr_t ab;
   logic  nmem;
   logic  nio;
   logic  cycle_done;
   logic  nsysdev;
   logic  niodev1;
   logic  niodev2;
   logic  niodev3;
   logic  naindex;

   // run statistics
   int     error_count   = 0;
   int     check_count   = 0;
   int     errors_before = 0;
   int     tests_run     = 0;
   int     tests_failed  = 0;
   int     clk_count     = 0;
   integer seed          = 32'h1308_132e;

   // event counters for the directed checks
   int mem_clks    = 0;
   int done_pulses = 0;
   int select_hits = 0;

   // reference model state
   int    ref_busy;
   logic  ref_io;
   logic  ref_fetch;
   addr_t ref_ar;
   addr_t ref_ab;
   logic  ref_naindex;
   logic  exp_nmem;
   logic  exp_nio;
   logic  exp_done;

   `include "address_unit_model.svh"

   address_unit #(
      .CYCLE_LEN(CYCLE_LEN)
   ) i_address_unit (
      .clk       (clk),
      .rst_n     (rst_n),
      .ibus      (ibus),
      .nwar      (nwar),
      .mem_req   (mem_req),
      .io_req    (io_req),
      .fetch     (fetch),
      .end_instr (end_instr),
      .ab        (ab),
      .nmem      (nmem),
      .nio       (nio),
      .cycle_done(cycle_done),
      .nsysdev   (nsysdev),
      .niodev1   (niodev1),
      .niodev2   (niodev2),
      .niodev3   (niodev3),
      .naindex   (naindex)
   );

   // 20 ns clock
   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   ////////////////////////////////////////////////////////////
   // reference model and checker
   ////////////////////////////////////////////////////////////

   // ref_busy counts the strobe clocks still to come, 0 when idle
   assign exp_nmem = !((ref_busy != 0) && !ref_io);
   assign exp_nio  = !((ref_busy != 0) && ref_io);
   assign exp_done = (ref_busy == 1);

   always @(posedge clk) begin
      if (!rst_n) begin
         ref_busy    <= 0;
         ref_io      <= 1'b0;
         ref_fetch   <= 1'b0;
         ref_ar      <= '0;
         ref_ab      <= '0;
         ref_naindex <= 1'b1;
      end else begin
         if (!nwar) begin
            ref_ar <= ibus;
         end
         // bus picks up ar one clock late while a strobe is low
         if (ref_busy != 0) begin
            ref_ab <= ref_ar;
         end
         // end of instruction beats a fetch ending in the same clock
         if (end_instr) begin
            ref_naindex <= 1'b1;
         end else if ((ref_busy == 1) && !ref_io && ref_fetch) begin
            ref_naindex <= !in_autoindex_window(ref_ar);
         end
         if (ref_busy == 0) begin
            if (mem_req) begin
               ref_busy  <= CYCLE_LEN;
               ref_io    <= 1'b0;
               ref_fetch <= fetch;
            end else if (io_req) begin
               ref_busy  <= CYCLE_LEN;
               ref_io    <= 1'b1;
               ref_fetch <= 1'b0;
            end
         end else begin
            ref_busy <= ref_busy - 1;
         end
      end
   end

   always @(negedge clk) begin
      if (rst_n === 1'b1) begin
         check_value("nmem", 16'(exp_nmem), 16'(nmem));
         check_value("nio", 16'(exp_nio), 16'(nio));
         check_value("cycle_done", 16'(exp_done), 16'(cycle_done));
         check_value("ab", ref_ab, ab);
         check_value("device selects", 16'(expected_selects(ref_ab, !exp_nio)),
                     16'({nsysdev, niodev1, niodev2, niodev3}));
         check_value("naindex", 16'(ref_naindex), 16'(naindex));
         if (!nmem) begin
            mem_clks++;
         end
         if (cycle_done) begin
            done_pulses++;
         end
         if (!(nsysdev && niodev1 && niodev2 && niodev3)) begin
            select_hits++;
         end
      end
   end

   // run limit from the number of requested cycles
   always @(posedge clk) begin
      clk_count <= clk_count + 1;
      if (clk_count >= TIMEOUT_CLKS) begin
         $display("timeout: tests did not finish within %0d clocks", TIMEOUT_CLKS);
         $display(">>> FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // stimulus tasks
   ////////////////////////////////////////////////////////////

   // all tasks start and end in the time step of a rising edge

   task automatic load_ar(input addr_t a);
      nwar <= 1'b0;
      ibus <= a;
      @(posedge clk);
      nwar <= 1'b1;
   endtask

   // returns on the edge where the cycle ends
   task automatic wait_done;
      do begin
         @(negedge clk);
      end while (cycle_done !== 1'b1);
      @(posedge clk);
   endtask

   task automatic run_cycle(input logic is_io, input logic is_fetch);
      mem_req <= !is_io;
      io_req  <= is_io;
      fetch   <= is_fetch;
      @(posedge clk);
      mem_req <= 1'b0;
      io_req  <= 1'b0;
      wait_done();
      fetch   <= 1'b0;
   endtask

   task automatic report_test(input string name);
      tests_run++;
      if (error_count == errors_before) begin
         $display("test %-18s ok", name);
      end else begin
         tests_failed++;
         $display("test %-18s %0d errors", name, error_count - errors_before);
      end
      errors_before = error_count;
   endtask

   ////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////

   initial begin
      addr_t addr;
      addr_t outside;
      rst_n     <= 1'b0;
      ibus      <= '0;
      nwar      <= 1'b1;
      mem_req   <= 1'b0;
      io_req    <= 1'b0;
      fetch     <= 1'b0;
      end_instr <= 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;

      // 1: reset values
      @(negedge clk);
      check_value("nmem", 16'd1, 16'(nmem));
      check_value("nio", 16'd1, 16'(nio));
      check_value("naindex", 16'd1, 16'(naindex));
      check_value("cycle_done", 16'd0, 16'(cycle_done));
      check_value("ab", 16'h0000, ab);
      @(posedge clk);
      report_test("reset values");

      // 2: one memory cycle, then bus hold
      addr = addr_t'($random(seed));
      load_ar(addr);
      mem_clks    = 0;
      done_pulses = 0;
      run_cycle(1'b0, 1'b0);
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_value("nmem clocks", 16'(CYCLE_LEN), 16'(mem_clks));
      check_value("cycle_done pulses", 16'd1, 16'(done_pulses));
      check_value("ab", addr, ab);
      @(posedge clk);
      report_test("memory cycle");

      // 3: io decode on random addresses, with memory cycles between
      select_hits = 0;
      for (int i = 0; i < NUM_IO; i++) begin
         addr = addr_t'($random(seed));
         // half of them inside the device window
         if (i % 2 == 0) begin
            addr[15:11] = 5'b00000;
         end
         load_ar(addr);
         run_cycle(1'b1, 1'b0);
         if (i % 4 == 3) begin
            run_cycle(1'b0, 1'b0);
         end
      end
      if (select_hits == 0) begin
         error_count++;
         $display("no device select went low during the io cycles");
      end
      report_test("io decode");

      // 4: request rules
      load_ar(addr_t'($random(seed)));
      mem_req <= 1'b1;
      io_req  <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      check_value("nmem", 16'd0, 16'(nmem));
      check_value("nio", 16'd1, 16'(nio));
      // both still high for one busy clock, to be dropped
      @(posedge clk);
      mem_req <= 1'b0;
      io_req  <= 1'b0;
      wait_done();
      // first clock back in idle
      io_req <= 1'b1;
      @(posedge clk);
      io_req <= 1'b0;
      @(negedge clk);
      check_value("nio", 16'd0, 16'(nio));
      @(posedge clk);
      wait_done();
      report_test("request rules");

      // 5: autoindex flag
      addr    = 16'h0080 | (addr_t'($random(seed)) & 16'h007f);
      outside = addr_t'($random(seed)) | 16'h0100;
      load_ar(addr);
      run_cycle(1'b0, 1'b1);
      @(negedge clk);
      check_value("naindex", 16'd0, 16'(naindex));
      @(posedge clk);
      // later accesses outside the window keep the flag
      load_ar(outside);
      run_cycle(1'b0, 1'b0);
      run_cycle(1'b1, 1'b0);
      @(negedge clk);
      check_value("naindex", 16'd0, 16'(naindex));
      @(posedge clk);
      end_instr <= 1'b1;
      @(posedge clk);
      end_instr <= 1'b0;
      @(negedge clk);
      check_value("naindex", 16'd1, 16'(naindex));
      @(posedge clk);
      // fetch outside the window
      run_cycle(1'b0, 1'b1);
      @(negedge clk);
      check_value("naindex", 16'd1, 16'(naindex));
      @(posedge clk);
      // data accesses inside the window
      load_ar(addr);
      run_cycle(1'b0, 1'b0);
      run_cycle(1'b1, 1'b0);
      @(negedge clk);
      check_value("naindex", 16'd1, 16'(naindex));
      @(posedge clk);
      report_test("autoindex");

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, check_count, error_count);
      if (error_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: hdl/address_unit.sv
`timescale 1ns/1ns
`default_nettype none

// address side of the cpu: ar, bus sequencer, ab drive,
// device decode and autoindex flag
module address_unit import addr_pkg::*; #(
   parameter int CYCLE_LEN = 4
) (
   input  wire   clk,
   input  wire   rst_n,
   input  addr_t ibus,
   input  wire   nwar,
   input  wire   mem_req,
   input  wire   io_req,
   input  wire   fetch,
   input  wire   end_instr,
   output addr_t ab,
   output logic  nmem,
   output logic  nio,
   output logic  cycle_done,
   output logic  nsysdev,
   output logic  niodev1,
   output logic  niodev2,
   output logic  niodev3,
   output logic  naindex
);

   addr_t ar;
   // sequencer internals
   logic  run;
   logic  last_phase;
   logic  fetch_done;

   ////////////////////////////////////////////////////////////
   // address register
   ////////////////////////////////////////////////////////////

   address_register i_address_register (
      .clk  (clk),
      .rst_n(rst_n),
      .nwar (nwar),
      .ibus (ibus),
      .ar   (ar)
   );

   ////////////////////////////////////////////////////////////
   // bus cycle sequencer
   ////////////////////////////////////////////////////////////

   bus_cycle_fsm #(
      .CYCLE_LEN(CYCLE_LEN)
   ) i_bus_cycle_fsm (
      .clk       (clk),
      .rst_n     (rst_n),
      .mem_req   (mem_req),
      .io_req    (io_req),
      .fetch     (fetch),
      .last_phase(last_phase),
      .run       (run),
      .nmem      (nmem),
      .nio       (nio),
      .cycle_done(cycle_done),
      .fetch_done(fetch_done)
   );

   // phase count itself is not needed outside the timer
   phase_timer #(
      .CYCLE_LEN(CYCLE_LEN)
   ) i_phase_timer (
      .clk       (clk),
      .rst_n     (rst_n),
      .run       (run),
      .phase     (),
      .last_phase(last_phase)
   );

   ////////////////////////////////////////////////////////////
   // bus drive and decode
   ////////////////////////////////////////////////////////////

   address_bus_driver i_address_bus_driver (
      .clk  (clk),
      .rst_n(rst_n),
      .nmem (nmem),
      .nio  (nio),
      .ar   (ar),
      .ab   (ab)
   );

   // decodes from ab, as the devices would see it
   device_decoder i_device_decoder (
      .ab     (ab),
      .nio    (nio),
      .nsysdev(nsysdev),
      .niodev1(niodev1),
      .niodev2(niodev2),
      .niodev3(niodev3)
   );

   autoindex_detect i_autoindex_detect (
      .clk       (clk),
      .rst_n     (rst_n),
      .ar        (ar),
      .fetch_done(fetch_done),
      .end_instr (end_instr),
      .naindex   (naindex)
   );

endmodule

`default_nettype wire

// File: hdl/autoindex_detect.sv
`timescale 1ns/1ns
`default_nettype none

// autoindex logic
// flags a fetch from 0x0080..0x00ff and keeps the flag for the
// whole instruction, since indirect accesses reuse ar later on
module autoindex_detect import addr_pkg::*; (
   input  wire   clk,
   input  wire   rst_n,
   input  addr_t ar,
   input  wire   fetch_done,
   input  wire   end_instr,
   output logic  naindex
);

   ////////////////////////////////////////////////////////////
   // window match
   ////////////////////////////////////////////////////////////

   // nine-bit compare: ar[15:7] against 0_0000_0001
   // the low seven bits are masked off
   logic ai_hit;

   assign ai_hit = ((ar & AINDEX_MASK) == AINDEX_BASE);

   ////////////////////////////////////////////////////////////
   // flag register
   ////////////////////////////////////////////////////////////

   // sampled once, at the end of the fetch cycle
   // end of instruction has priority over a fetch
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         naindex <= 1'b1;
      end else if (end_instr) begin
         // back to inactive for the next instruction
         naindex <= 1'b1;
      end else if (fetch_done) begin
         naindex <= !ai_hit;
      end
   end

   // in all other clocks the flag simply holds,
   // whatever happens to ar in the meantime

endmodule

`default_nettype wire

// File: hdl/device_decoder.sv
`timescale 1ns/1ns
`default_nettype none

// sysdev / iodev select decoder
// window compare on ab[15:11] qualified by nio,
// then a 3-to-8 demux on the page bits, only 4 outputs used
module device_decoder import addr_pkg::*; (
   input  addr_t ab,
   input  wire   nio,
   output logic  nsysdev,
   output logic  niodev1,
   output logic  niodev2,
   output logic  niodev3
);

   ////////////////////////////////////////////////////////////
   // window compare
   ////////////////////////////////////////////////////////////

   // high when an io cycle addresses the system window
   logic      sys_hit;
   dev_page_t page;

   assign sys_hit = !nio && (ab[15:11] == SYS_WINDOW_HI);

   // page bits pick one of the devices
   assign page = ab[10:8];

   ////////////////////////////////////////////////////////////
   // page demux
   ////////////////////////////////////////////////////////////

   // active low selects, all high outside an io cycle
   assign nsysdev = !(sys_hit && (page == PAGE_SYSDEV));
   assign niodev1 = !(sys_hit && (page == PAGE_IODEV1));
   assign niodev2 = !(sys_hit && (page == PAGE_IODEV2));
   assign niodev3 = !(sys_hit && (page == PAGE_IODEV3));

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   // two devices on the data bus at once would fight,
   // checked once the delta cycle has settled
   always_comb begin
      a_one_select : assert final (
         $onehot0({~nsysdev, ~niodev1, ~niodev2, ~niodev3})
      ) else $error("more than one device select low");
   end

endmodule

`default_nettype wire

// File: hdl/address_bus_driver.sv
`timescale 1ns/1ns
`default_nettype none

// address bus drive
// on the board a pair of buffers enabled by nmem & nio,
// with bus hold keeping the last value between cycles
module address_bus_driver import addr_pkg::*; (
   input  wire   clk,
   input  wire   rst_n,
   input  wire   nmem,
   input  wire   nio,
   input  addr_t ar,
   output addr_t ab
);

   ////////////////////////////////////////////////////////////
   // drive enable
   ////////////////////////////////////////////////////////////

   // either strobe low enables the buffers
   logic ab_en;

   assign ab_en = !nmem || !nio;

   ////////////////////////////////////////////////////////////
   // bus register
   ////////////////////////////////////////////////////////////

   // ab follows ar one clock late while enabled
   // when disabled the old value stays, standing in for bus hold
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ab <= '0;
      end else if (ab_en) begin
         ab <= ar;
      end
   end

endmodule

`default_nettype wire

// File: bus_sequencer/bus_cycle_fsm.sv
`timescale 1ns/1ns
`default_nettype none

// bus cycle sequencer
// takes one request in idle, runs a memory or io cycle of
// CYCLE_LEN clocks and returns to idle
module bus_cycle_fsm import cycle_pkg::*; #(
   parameter int CYCLE_LEN = 4
) (
   input  wire  clk,
   input  wire  rst_n,
   input  wire  mem_req,
   input  wire  io_req,
   input  wire  fetch,
   input  wire  last_phase,
   output logic run,
   output logic nmem,
   output logic nio,
   output logic cycle_done,
   output logic fetch_done
);

   bus_state_t state;
   bus_state_t state_nxt;
   // fetch qualifier, latched along with the memory request
   logic       fetch_q;

   ////////////////////////////////////////////////////////////
   // state register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= st_idle;
         fetch_q <= 1'b0;
      end else begin
         state <= state_nxt;
         // only sampled in idle, held through the cycle
         if (state == st_idle) begin
            fetch_q <= mem_req && fetch;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // next state
   ////////////////////////////////////////////////////////////

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            // memory wins when both ask together
            if (mem_req) begin
               state_nxt = st_mem;
            end else if (io_req) begin
               state_nxt = st_io;
            end
         end
         // busy: requests are dropped until the timer ends the cycle
         st_mem, st_io: begin
            if (last_phase) begin
               state_nxt = st_idle;
            end
         end
         default: state_nxt = st_idle;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // outputs
   ////////////////////////////////////////////////////////////

   assign run        = (state != st_idle);
   assign nmem       = (state != st_mem);
   assign nio        = (state != st_io);
   // one clock, in the last phase only
   assign cycle_done = run && last_phase;
   assign fetch_done = cycle_done && fetch_q && (state == st_mem);

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   a_strobes_excl : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(!nmem && !nio)
   ) else $error("nmem and nio low together");

   // the timer must close every cycle after exactly CYCLE_LEN clocks
   a_cycle_len : assert property (
      @(posedge clk) disable iff (!rst_n)
      $rose(run) |-> ##(CYCLE_LEN - 1) cycle_done
   ) else $error("cycle_done not in phase CYCLE_LEN-1");

endmodule

`default_nettype wire

// File: bus_sequencer/phase_timer.sv
`timescale 1ns/1ns
`default_nettype none

// phase counter for one bus cycle
// 0 on the first clock of a cycle, last_phase on CYCLE_LEN-1
module phase_timer import cycle_pkg::*; #(
   parameter int CYCLE_LEN = 4
) (
   input  wire    clk,
   input  wire    rst_n,
   input  wire    run,
   output phase_t phase,
   output logic   last_phase
);

   // phase_t is three bits wide
   if (CYCLE_LEN < 2 || CYCLE_LEN > 7) begin : g_len_check
      $error("CYCLE_LEN must be 2..7");
   end

   ////////////////////////////////////////////////////////////
   // counter
   ////////////////////////////////////////////////////////////

   // parked at zero while idle, wraps on the last phase so the
   // count is ready for a cycle starting right after
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         phase <= '0;
      end else if (!run || last_phase) begin
         phase <= '0;
      end else begin
         phase <= phase + 1'b1;
      end
   end

   assign last_phase = (phase == phase_t'(CYCLE_LEN - 1));

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   a_phase_range : assert property (
      @(posedge clk) disable iff (!rst_n)
      phase <= phase_t'(CYCLE_LEN - 1)
   ) else $error("phase beyond CYCLE_LEN-1");

endmodule

`default_nettype wire

// File: hdl/address_register.sv
`timescale 1ns/1ns
`default_nettype none

// address register, two 8-bit halves on the schematic
// modelled here as a single 16-bit register
module address_register import addr_pkg::*; (
   input  wire   clk,
   input  wire   rst_n,
   input  wire   nwar,
   input  addr_t ibus,
   output addr_t ar
);

   ////////////////////////////////////////////////////////////
   // register
   ////////////////////////////////////////////////////////////

   // nwar is a sampled enable, not a clock as on the board
   // load takes effect one edge after nwar is seen low
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ar <= '0;
      end else if (!nwar) begin
         ar <= ibus;
      end
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   // ar feeds the bus driver and the autoindex compare
   // an unknown here would leak onto ab and into naindex
   a_ar_known : assert property (
      @(posedge clk) disable iff (!rst_n)
      !$isunknown(ar)
   ) else $error("ar went unknown after reset");

endmodule

`default_nettype wire

// File: common/cycle_pkg.sv
`default_nettype none

package cycle_pkg;

   ////////////////////////////////////////////////////////////
   // bus cycle sequencing
   ////////////////////////////////////////////////////////////

   // one state per cycle kind
   // the state itself drives the strobes
   typedef enum logic [1:0] {
      st_idle = 2'd0,
      st_mem  = 2'd1,
      st_io   = 2'd2
   } bus_state_t;

   // phase counter within a cycle
   // three bits cover cycle lengths up to 7
   typedef logic [2:0] phase_t;

endpackage

`default_nettype wire

// File: common/addr_pkg.sv
`default_nettype none

package addr_pkg;

   ////////////////////////////////////////////////////////////
   // address widths
   ////////////////////////////////////////////////////////////

   // full 16-bit address, as held in ar and driven on ab
   typedef logic [15:0] addr_t;

   // device page, taken from ab[10:8] during an io cycle
   typedef logic [2:0] dev_page_t;

   ////////////////////////////////////////////////////////////
   // device map
   ////////////////////////////////////////////////////////////

   // ab[15:11] must equal this for any system or io device
   localparam logic [4:0] SYS_WINDOW_HI = 5'b00000;

   // pages 0..3 select devices, pages 4..7 are unused
   localparam dev_page_t PAGE_SYSDEV = 3'd0;
   localparam dev_page_t PAGE_IODEV1 = 3'd1;
   localparam dev_page_t PAGE_IODEV2 = 3'd2;
   localparam dev_page_t PAGE_IODEV3 = 3'd3;

   ////////////////////////////////////////////////////////////
   // autoindex window
   ////////////////////////////////////////////////////////////

   // 0x0080..0x00ff, i.e. ar matches 0000_0000_1xxx_xxxx
   // the mask keeps the nine upper bits of the compare
   localparam addr_t AINDEX_BASE = 16'h0080;
   localparam addr_t AINDEX_MASK = 16'hff80;

endpackage

`default_nettype wire
